/* run.sh */
#!/usr/bin/env bash
# build and run the testbench with verilator, verdict from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f tb.f --top-module vg_sys_ctrl_tb \
  -Mdir obj_dir -o vg_sys_ctrl_tb \
  && ./obj_dir/vg_sys_ctrl_tb 2>&1 | tee sim.log
grep -q "Finished with no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* tb.f */
+incdir+.
vg_bus_pkg.sv
vg_io_pkg.sv
vg_io_regs.sv
vg_mem_decode.sv
vg_read_mux.sv
vg_sys_ctrl.sv
vg_sys_ctrl_tb.sv

/* vg_bus_pkg.sv */
`default_nettype none

package vg_bus_pkg;

  // z80 side of the glue, all strobes active low
  typedef struct packed {
    logic [15:0] addr;    // cpu address
    logic [7:0]  wdata;   // data driven by the cpu
    logic        mreq_n;  // memory cycle
    logic        iorq_n;  // i/o cycle
    logic        rd_n;    // read strobe
    logic        wr_n;    // write strobe
    logic        m1_n;    // opcode fetch
  } cpu_bus_t;

  // external memory that a request goes to
  typedef enum logic [2:0] {
    tgt_none,     // nothing selected
    tgt_rom,
    tgt_ram,
    tgt_vram,     // character codes
    tgt_aram,     // attributes, same addressing as vram
    tgt_hrg,      // high resolution graphics
    tgt_chargen   // character generator, through port FD
  } mem_tgt_e;

  // one decoded request toward the memories
  typedef struct packed {
    mem_tgt_e    tgt;     // selected memory
    logic [15:0] addr;    // address inside that memory
    logic        we;      // write strobe, qualified
    logic [7:0]  wdata;   // write data
  } mem_req_t;

  // kind of cycle the bus carries right now
  typedef enum logic [1:0] {
    sel_io_page,  // memory cycle on the active register page
    sel_io_ext,   // any i/o cycle
    sel_mem,      // plain memory cycle
    sel_open      // bus idle
  } bus_sel_e;

endpackage

`default_nettype wire

/* vg_config.svh */
`ifndef VG_CONFIG_SVH
`define VG_CONFIG_SVH

// register page selection, high address byte of a memory cycle
`define VG_IO_PAGE        8'hFB     // always decoded
`define VG_IO_PAGE_ALT    8'h1B     // only while rom_off is clear
`define VG_PORT_HRG0      8'h00     // hrg port 0, status on read
`define VG_PORT_HRG1      8'h01     // hrg port 1, bank select
`define VG_PORT_CTRL      8'hFC     // control port, key code on read
`define VG_PORT_COUNTER   8'hFD     // scroll counter or chargen data
`define VG_PORT_LATCH     8'hFE     // row/char latch, status on read
`define VG_OPEN_BUS       8'hFF     // floating data bus value

// memory map windows
`define VG_VID_LO         16'hF000  // video window start
`define VG_VID_HI         16'hF5FF  // video window end
`define VG_ROM_HI_LO      16'hE000  // upper rom, runs up to the video window
`define VG_ROM_EXT_LO     16'hF600  // rom extension window
`define VG_ROM_EXT_HI     16'hF9FF
`define VG_ROM_EXT_BASE   16'h1000  // where the extension lands in rom
`define VG_RAM_TOP_LO     16'hFC00  // top ram, always mapped
`define VG_ROM_LOW_LO     16'h1C00  // remapped low rom block
`define VG_ROM_LOW_HI     16'h1DFF
`define VG_ROM_LOW_BASE   16'h1400  // rom offset of the low block
`define VG_RAM_LOW_LO     16'h4000  // low ram, 14 bit window
`define VG_RAM_LOW_HI     16'h7FFF
`define VG_ROM_OFF_TOP    16'hE000  // ram below this with rom switched out

// screen and hrg geometry
`define VG_SCREEN_ROWS    24
`define VG_SCREEN_COLS    80
`define VG_HRG_BANK       1280      // bytes per full hrg bank
`define VG_HRG_BANKS      12        // number of full banks
`define VG_HRG_TAIL_BASE  15360     // small banks start after the full ones
`define VG_HRG_TAIL_BANK  256       // bytes per small bank
`define VG_NMI_BIT        3         // nmi counter bit that pulls nmi low

`endif

/* vg_io_pkg.sv */
`default_nettype none

`include "vg_config.svh"

package vg_io_pkg;

  // low address byte of a register page access
  typedef enum logic [7:0] {
    port_hrg0    = `VG_PORT_HRG0,
    port_hrg1    = `VG_PORT_HRG1,
    port_ctrl    = `VG_PORT_CTRL,
    port_counter = `VG_PORT_COUNTER,
    port_latch   = `VG_PORT_LATCH
  } io_port_e;

  // control port bits
  typedef struct packed {
    logic rom_off;       // rom switched out, ram from 0000
    logic aram_sel;      // video window hits attribute ram
    logic mode80;        // 80 column layout
    logic counter_lock;  // freeze scroll counter
    logic chargen_sel;   // port FD/FE go to the character generator
    logic spare;
    logic nmi_mask;      // stop nmi counting, a written one also clears it
    logic key_keep;      // a written zero drops key ready
  } ctrl_reg_t;

  // register state used by decode and read back
  typedef struct packed {
    ctrl_reg_t   ctrl;
    logic [4:0]  counter;     // scroll offset in rows
    logic [7:0]  hrg0;        // bit2 maps hrg into the video window
    logic [7:0]  hrg1;        // hrg bank select
    logic [3:0]  row_latch;   // text row / chargen line
    logic [7:0]  char_latch;  // chargen character, bit7 write enable
    logic        key_ready;
    logic        nmi_n;
  } io_regs_t;

  // settings toward the display side
  typedef struct packed {
    logic        mode80;
    logic [4:0]  counter;
    logic [7:0]  hrg0;
    logic [7:0]  hrg1;
  } video_cfg_t;

endpackage

`default_nettype wire

/* vg_io_regs.sv */
`default_nettype none

`include "vg_config.svh"

module vg_io_regs
  import vg_bus_pkg::*, vg_io_pkg::*;
(
  input  wire logic     w_clk_cpu,
  input  wire logic     w_cpu_reset,
  input  wire cpu_bus_t i_bus,
  input  wire bus_sel_e i_sel,
  input  wire logic     i_key_press,
  output io_regs_t      o_regs
);

  ctrl_reg_t  r_ctrl;
  logic [4:0] r_counter;
  logic [7:0] r_hrg0;
  logic [7:0] r_hrg1;
  logic [3:0] r_row_latch;
  logic [7:0] r_char_latch;
  logic       r_key_ready;
  logic [3:0] r_nmi_cnt;      // opcode fetch counter
  logic       r_m1_n;         // m1_n one edge back
  logic       w_page_wr;
  logic       w_ctrl_wr;
  logic       w_m1_fall;
  io_port_e   w_port;
  ctrl_reg_t  w_ctrl_new;     // value being written to port FC

  assign w_page_wr  = (i_sel == sel_io_page) && !i_bus.mreq_n && !i_bus.wr_n;
  assign w_port     = io_port_e'(i_bus.addr[7:0]);
  assign w_ctrl_wr  = w_page_wr && (w_port == port_ctrl);
  assign w_ctrl_new = ctrl_reg_t'(i_bus.wdata);
  assign w_m1_fall  = r_m1_n && !i_bus.m1_n;  // start of an opcode fetch

  always_ff @(posedge w_clk_cpu or negedge w_cpu_reset) begin
    if (!w_cpu_reset) begin
      r_ctrl       <= '0;
      r_counter    <= '0;
      r_hrg0       <= '0;
      r_hrg1       <= '0;
      r_row_latch  <= '0;
      r_char_latch <= '0;
    end else if (w_page_wr) begin
      case (w_port)
        port_hrg0: r_hrg0 <= i_bus.wdata;
        port_hrg1: r_hrg1 <= i_bus.wdata;
        port_ctrl: r_ctrl <= w_ctrl_new;
        port_counter: begin
          if (!r_ctrl.counter_lock && !r_ctrl.chargen_sel) begin
            r_counter <= i_bus.wdata[4:0];  // FD is chargen data otherwise
          end
        end
        port_latch: begin
          if (r_ctrl.chargen_sel) begin
            r_char_latch <= i_bus.wdata;
          end else begin
            r_row_latch <= i_bus.wdata[3:0];
          end
        end
        default: ;  // rest of the page is read only
      endcase
    end
  end

  // key flag, a new key beats a clear in the same cycle
  always_ff @(posedge w_clk_cpu or negedge w_cpu_reset) begin
    if (!w_cpu_reset) begin
      r_key_ready <= 1'b0;
    end else if (i_key_press) begin
      r_key_ready <= 1'b1;
    end else if (w_ctrl_wr && !w_ctrl_new.key_keep) begin
      r_key_ready <= 1'b0;
    end
  end

  // nmi after 8 fetches, a clear beats a fetch in the same cycle
  always_ff @(posedge w_clk_cpu or negedge w_cpu_reset) begin
    if (!w_cpu_reset) begin
      r_nmi_cnt <= '0;
      r_m1_n    <= 1'b1;  // idle level, no fetch seen
    end else begin
      r_m1_n <= i_bus.m1_n;
      if (w_ctrl_wr && w_ctrl_new.nmi_mask) begin
        r_nmi_cnt <= '0;
      end else if (w_m1_fall && !r_ctrl.nmi_mask) begin
        r_nmi_cnt <= r_nmi_cnt + 4'd1;
      end
    end
  end

  always_comb begin
    o_regs.ctrl       = r_ctrl;
    o_regs.counter    = r_counter;
    o_regs.hrg0       = r_hrg0;
    o_regs.hrg1       = r_hrg1;
    o_regs.row_latch  = r_row_latch;
    o_regs.char_latch = r_char_latch;
    o_regs.key_ready  = r_key_ready;
    o_regs.nmi_n      = ~r_nmi_cnt[`VG_NMI_BIT];
  end

  // a masking ctrl write always releases nmi on the next cycle
  a_nmi_release: assert property (@(posedge w_clk_cpu) disable iff (!w_cpu_reset)
    w_ctrl_wr && w_ctrl_new.nmi_mask |=> o_regs.nmi_n)
    else $error("nmi_n low after ctrl write with nmi_mask set");

  // locked scroll counter holds across the edge
  a_counter_lock: assert property (@(posedge w_clk_cpu) disable iff (!w_cpu_reset)
    r_ctrl.counter_lock |=> $stable(r_counter))
    else $error("scroll counter moved while locked");

endmodule

`default_nettype wire

/* vg_mem_decode.sv */
`default_nettype none

`include "vg_config.svh"

module vg_mem_decode
  import vg_bus_pkg::*, vg_io_pkg::*;
(
  input  wire cpu_bus_t i_bus,
  input  wire io_regs_t i_regs,
  output bus_sel_e      o_sel,
  output mem_req_t      o_mem_req
);

  logic [15:0] w_a;
  logic [7:0]  w_page;
  logic        w_page_hit;
  logic        w_cg_hit;
  logic        w_wr;
  logic        w_tgt_wr_ok;
  logic [4:0]  w_row;
  logic [6:0]  w_col;
  logic [15:0] w_vid_addr;
  logic [15:0] w_hrg_addr;
  logic [15:0] w_cg_addr;
  mem_tgt_e    w_tgt;
  logic [15:0] w_addr;

  // row + counter is at most 62, two subtractions bring it below 24
  function automatic logic [4:0] wrap_row(input logic [5:0] sum);
    logic [5:0] v;
    v = sum;
    if (v >= 6'(`VG_SCREEN_ROWS)) v = v - 6'(`VG_SCREEN_ROWS);
    if (v >= 6'(`VG_SCREEN_ROWS)) v = v - 6'(`VG_SCREEN_ROWS);
    return v[4:0];
  endfunction

  assign w_a        = i_bus.addr;
  assign w_page     = w_a[15:8];
  assign w_page_hit = (w_page == `VG_IO_PAGE) ||
                      ((w_page == `VG_IO_PAGE_ALT) && !i_regs.ctrl.rom_off);
  assign w_cg_hit   = (w_a[7:0] == port_counter) && i_regs.ctrl.chargen_sel;
  assign w_wr       = !i_bus.mreq_n && !i_bus.wr_n;

  always_comb begin
    if (!i_bus.iorq_n) o_sel = sel_io_ext;
    else if (i_bus.mreq_n) o_sel = sel_open;  // no cycle in progress
    else if (w_page_hit) o_sel = sel_io_page;
    else o_sel = sel_mem;
  end

  // text layout, 80 col uses the row latch as the high row bits
  assign w_row = i_regs.ctrl.mode80 ? {i_regs.row_latch, w_a[7]} : w_a[10:6];
  assign w_col = i_regs.ctrl.mode80 ? w_a[6:0] : {1'b0, w_a[5:0]};
  assign w_vid_addr = 16'(wrap_row(6'(w_row) + 6'(i_regs.counter))) * 16'(`VG_SCREEN_COLS)
                    + 16'(w_col);

  always_comb begin
    if (i_regs.hrg1[3:0] < 4'(`VG_HRG_BANKS)) begin
      w_hrg_addr = 16'(i_regs.hrg1[3:0]) * 16'(`VG_HRG_BANK) + 16'(w_a[10:0]);
    end else begin
      w_hrg_addr = 16'(i_regs.hrg1[1:0]) * 16'(`VG_HRG_TAIL_BANK) + 16'(w_a[7:0])
                 + 16'(`VG_HRG_TAIL_BASE);  // 256 byte tail banks
    end
  end

  assign w_cg_addr = {4'h0, i_regs.char_latch, i_regs.row_latch};  // char*16 | line

  always_comb begin
    w_tgt  = tgt_rom;  // rom at the raw address unless something wins
    w_addr = w_a;
    if (!i_bus.iorq_n) begin
      w_tgt = tgt_none;  // i/o cycle, memories idle
    end else if (w_page_hit) begin
      if (w_cg_hit) begin
        w_tgt  = tgt_chargen;
        w_addr = w_cg_addr;
      end else begin
        w_tgt = tgt_none;  // served by the register block
      end
    end else if (w_a >= `VG_VID_LO && w_a <= `VG_VID_HI) begin
      if (i_regs.hrg0[2]) begin
        w_tgt  = tgt_hrg;
        w_addr = w_hrg_addr;
      end else begin
        w_tgt  = i_regs.ctrl.aram_sel ? tgt_aram : tgt_vram;
        w_addr = w_vid_addr;
      end
    end else if (w_a >= `VG_ROM_HI_LO && w_a < `VG_VID_LO) begin
      w_addr = {4'h0, w_a[11:0]};
    end else if (w_a >= `VG_ROM_EXT_LO && w_a <= `VG_ROM_EXT_HI) begin
      w_addr = `VG_ROM_EXT_BASE + {6'h00, w_a[11], w_a[8:0]};  // two 512 byte halves
    end else if (w_a >= `VG_RAM_TOP_LO) begin
      w_tgt = tgt_ram;
    end else if (!i_regs.ctrl.rom_off) begin
      if (w_a >= `VG_RAM_LOW_LO && w_a <= `VG_RAM_LOW_HI) begin
        w_tgt  = tgt_ram;
        w_addr = {2'b00, w_a[13:0]};
      end else if (w_a >= `VG_ROM_LOW_LO && w_a <= `VG_ROM_LOW_HI) begin
        w_addr = `VG_ROM_LOW_BASE + {7'h00, w_a[8:0]};
      end
    end else if (w_a < `VG_ROM_OFF_TOP) begin
      w_tgt = tgt_ram;  // rom switched out
    end
  end

  always_comb begin
    case (w_tgt)
      tgt_ram, tgt_vram, tgt_aram, tgt_hrg: w_tgt_wr_ok = 1'b1;
      tgt_chargen: w_tgt_wr_ok = i_regs.char_latch[7];  // write protect off
      default: w_tgt_wr_ok = 1'b0;
    endcase
  end

  assign o_mem_req.tgt   = w_tgt;
  assign o_mem_req.addr  = w_addr;
  assign o_mem_req.we    = w_wr && w_tgt_wr_ok;
  assign o_mem_req.wdata = i_bus.wdata;

  // sampled just before the write strobe lifts, i.e. over the whole write
  a_we_target: assert property (@(posedge i_bus.wr_n)
    o_mem_req.we |-> !(o_mem_req.tgt inside {tgt_rom, tgt_none}))
    else $error("write enable on rom or unmapped target");

endmodule

`default_nettype wire

/* vg_read_mux.sv */
`default_nettype none

`include "vg_config.svh"

module vg_read_mux
  import vg_bus_pkg::*, vg_io_pkg::*;
(
  input  wire bus_sel_e   i_sel,
  input  wire logic [7:0] i_addr_lo,
  input  wire io_regs_t   i_regs,
  input  wire logic [7:0] i_mem_rdata,
  input  wire logic [7:0] i_key_code,
  input  wire logic       i_hblank,
  input  wire logic       i_vblank,
  output logic [7:0]      o_cpu_rdata
);

  io_port_e   w_port;
  logic [7:0] w_page_rdata;

  assign w_port = io_port_e'(i_addr_lo);

  // register page read back
  always_comb begin
    case (w_port)
      port_hrg0: begin
        w_page_rdata = {6'b11_1111, ~i_hblank, ~i_vblank};  // blanking, inverted
      end
      port_ctrl: begin
        w_page_rdata = i_key_code;  // last key from the keyboard
      end
      port_counter: begin
        w_page_rdata = i_mem_rdata;  // chargen byte
      end
      port_latch: begin
        w_page_rdata = {i_hblank, i_vblank, 5'b0_0000, i_regs.key_ready};
      end
      default: begin
        w_page_rdata = 8'h00;  // hrg1 and unused offsets
      end
    endcase
  end

  always_comb begin
    case (i_sel)
      sel_io_page: o_cpu_rdata = w_page_rdata;
      sel_io_ext:  o_cpu_rdata = `VG_OPEN_BUS;  // no i/o devices left
      sel_mem:     o_cpu_rdata = i_mem_rdata;
      sel_open:    o_cpu_rdata = `VG_OPEN_BUS;
      default:     o_cpu_rdata = `VG_OPEN_BUS;
    endcase
  end

endmodule

`default_nettype wire

/* vg_sys_ctrl.sv */
`default_nettype none

module vg_sys_ctrl
  import vg_bus_pkg::*, vg_io_pkg::*;
(
  input  wire logic       w_clk_cpu,
  input  wire logic       w_cpu_reset,
  input  wire cpu_bus_t   i_bus,
  input  wire logic [7:0] i_mem_rdata,   // byte from the selected memory
  input  wire logic [7:0] i_key_code,
  input  wire logic       i_key_press,   // one cycle strobe per key
  input  wire logic       i_hblank,      // already in the cpu clock domain
  input  wire logic       i_vblank,
  output mem_req_t        o_mem_req,
  output logic [7:0]      o_cpu_rdata,
  output logic            o_nmi_n,
  output video_cfg_t      o_video_cfg
);

  bus_sel_e w_sel;   // cycle kind from the decoder
  io_regs_t w_regs;  // register state

  vg_mem_decode u_mem_decode (
    .i_bus     (i_bus),
    .i_regs    (w_regs),
    .o_sel     (w_sel),
    .o_mem_req (o_mem_req)
  );

  vg_io_regs u_io_regs (
    .w_clk_cpu   (w_clk_cpu),
    .w_cpu_reset (w_cpu_reset),
    .i_bus       (i_bus),
    .i_sel       (w_sel),
    .i_key_press (i_key_press),
    .o_regs      (w_regs)
  );

  vg_read_mux u_read_mux (
    .i_sel       (w_sel),
    .i_addr_lo   (i_bus.addr[7:0]),  // port offset on the register page
    .i_regs      (w_regs),
    .i_mem_rdata (i_mem_rdata),
    .i_key_code  (i_key_code),
    .i_hblank    (i_hblank),
    .i_vblank    (i_vblank),
    .o_cpu_rdata (o_cpu_rdata)
  );

  assign o_nmi_n     = w_regs.nmi_n;
  assign o_video_cfg = '{mode80:  w_regs.ctrl.mode80,
                         counter: w_regs.counter,
                         hrg0:    w_regs.hrg0,
                         hrg1:    w_regs.hrg1};

endmodule

`default_nettype wire

/* vg_sys_ctrl_tb.sv */
`default_nettype none

`include "vg_config.svh"

module vg_sys_ctrl_tb
  import vg_bus_pkg::*, vg_io_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  logic       w_clk_cpu;
  logic       w_cpu_reset;
  cpu_bus_t   bus;          // z80 cycle driven into the dut
  logic [7:0] mem_rdata;    // byte returned by the selected memory
  logic [7:0] key_code;
  logic       key_press;
  logic       hblank;
  logic       vblank;
  mem_req_t   mem_req;
  logic [7:0] cpu_rdata;
  logic       nmi_n;
  video_cfg_t video_cfg;
  io_regs_t   shadow;       // expected register state
  logic [3:0] nmi_cnt;      // expected opcode fetch count
  logic       prev_m1;      // m1_n of the previous cycle
  logic       check_en;

  vg_sys_ctrl i_dut (
    .w_clk_cpu   (w_clk_cpu),
    .w_cpu_reset (w_cpu_reset),
    .i_bus       (bus),
    .i_mem_rdata (mem_rdata),
    .i_key_code  (key_code),
    .i_key_press (key_press),
    .i_hblank    (hblank),
    .i_vblank    (vblank),
    .o_mem_req   (mem_req),
    .o_cpu_rdata (cpu_rdata),
    .o_nmi_n     (nmi_n),
    .o_video_cfg (video_cfg)
  );

  always #2 w_clk_cpu = ~w_clk_cpu;  // 4 ns period

  function automatic cpu_bus_t idle_bus();
    cpu_bus_t b;
    b = '{addr: 16'h0000, wdata: 8'h00, mreq_n: 1'b1, iorq_n: 1'b1,
          rd_n: 1'b1, wr_n: 1'b1, m1_n: 1'b1};
    return b;
  endfunction

  function automatic cpu_bus_t mem_read(input logic [15:0] a);
    cpu_bus_t b;
    b = idle_bus();
    b.addr = a;
    b.mreq_n = 1'b0;
    b.rd_n = 1'b0;
    return b;
  endfunction

  function automatic cpu_bus_t mem_write(input logic [15:0] a, input logic [7:0] d);
    cpu_bus_t b;
    b = idle_bus();
    b.addr = a;
    b.wdata = d;
    b.mreq_n = 1'b0;
    b.wr_n = 1'b0;
    return b;
  endfunction

  function automatic cpu_bus_t io_read(input logic [15:0] a);
    cpu_bus_t b;
    b = idle_bus();
    b.addr = a;
    b.iorq_n = 1'b0;
    b.rd_n = 1'b0;
    return b;
  endfunction

  function automatic cpu_bus_t opcode_fetch(input logic [15:0] a);
    cpu_bus_t b;
    b = mem_read(a);
    b.m1_n = 1'b0;  // falling m1 counts toward nmi
    return b;
  endfunction

  // mix of idle, i/o and memory cycles biased toward the mapped windows
  function automatic cpu_bus_t random_cycle();
    cpu_bus_t b;
    logic [15:0] a;
    int kind;
    a = 16'($urandom);
    case (int'($urandom % 8))
      0: a[15:12] = 4'hF;         // video, rom ext, top ram
      1: a[15:9] = 7'b0001_110;   // low rom block
      2: a[15:14] = 2'b01;        // low ram
      3: a[15:12] = 4'hE;         // upper rom
      default: ;
    endcase
    kind = int'($urandom % 8);
    case (kind)
      0: b = idle_bus();
      1: b = io_read(a);
      2: begin
        b = io_read(a);
        b.rd_n = 1'b1;  // i/o write
        b.wr_n = 1'b0;
      end
      3, 4, 5: b = mem_read(a);
      default: b = mem_write(a, 8'($urandom));
    endcase
    if (!b.wr_n && (a[15:8] == `VG_IO_PAGE || a[15:8] == `VG_IO_PAGE_ALT)) begin
      b = mem_read(a);  // register writes stay under test control
    end
    return b;
  endfunction

  function automatic cpu_bus_t video_cycle();
    logic [15:0] a;
    a = 16'(int'(`VG_VID_LO) + int'($urandom % 1536));  // F000..F5FF
    return ($urandom % 2) ? mem_write(a, 8'($urandom)) : mem_read(a);
  endfunction

  function automatic logic page_hit(input cpu_bus_t b, input io_regs_t r);
    return (b.addr[15:8] == `VG_IO_PAGE) ||
           (b.addr[15:8] == `VG_IO_PAGE_ALT && !r.ctrl.rom_off);
  endfunction

  // memory map, video and hrg formulas, chargen port
  function automatic mem_req_t ref_mem_req(input cpu_bus_t b, input io_regs_t r);
    mem_req_t m;
    logic [15:0] a;
    int row;
    int col;
    a = b.addr;
    m.tgt = tgt_rom;
    m.addr = a;
    m.wdata = b.wdata;
    if (!b.iorq_n) begin
      m.tgt = tgt_none;
    end else if (page_hit(b, r)) begin
      m.tgt = tgt_none;
      if (a[7:0] == `VG_PORT_COUNTER && r.ctrl.chargen_sel) begin
        m.tgt = tgt_chargen;
        m.addr = 16'(int'(r.char_latch) * 16 + int'(r.row_latch));
      end
    end else if (a >= `VG_VID_LO && a <= `VG_VID_HI) begin
      if (r.hrg0[2]) begin
        m.tgt = tgt_hrg;
        if (int'(r.hrg1[3:0]) < `VG_HRG_BANKS) begin
          m.addr = 16'(int'(r.hrg1[3:0]) * `VG_HRG_BANK + int'(a) % 2048);
        end else begin
          m.addr = 16'(`VG_HRG_TAIL_BASE + int'(r.hrg1[1:0]) * `VG_HRG_TAIL_BANK
                       + int'(a) % 256);
        end
      end else begin
        m.tgt = r.ctrl.aram_sel ? tgt_aram : tgt_vram;
        row = r.ctrl.mode80 ? int'(r.row_latch) * 2 + int'(a[7]) : (int'(a) / 64) % 32;
        col = r.ctrl.mode80 ? int'(a) % 128 : int'(a) % 64;
        m.addr = 16'(((row + int'(r.counter)) % `VG_SCREEN_ROWS) * `VG_SCREEN_COLS + col);
      end
    end else if (a >= `VG_ROM_HI_LO && a < `VG_VID_LO) begin
      m.addr = a - `VG_ROM_HI_LO;
    end else if (a >= `VG_ROM_EXT_LO && a <= `VG_ROM_EXT_HI) begin
      // F600-F7FF and F800-F9FF land back to back
      m.addr = (a < 16'hF800) ? a - `VG_ROM_EXT_LO + `VG_ROM_EXT_BASE
                              : a - 16'hF800 + `VG_ROM_EXT_BASE + 16'h0200;
    end else if (a >= `VG_RAM_TOP_LO) begin
      m.tgt = tgt_ram;
    end else if (!r.ctrl.rom_off) begin
      if (a >= `VG_RAM_LOW_LO && a <= `VG_RAM_LOW_HI) begin
        m.tgt = tgt_ram;
        m.addr = a - `VG_RAM_LOW_LO;
      end else if (a >= `VG_ROM_LOW_LO && a <= `VG_ROM_LOW_HI) begin
        m.addr = a - `VG_ROM_LOW_LO + `VG_ROM_LOW_BASE;
      end
    end else if (a < `VG_ROM_OFF_TOP) begin
      m.tgt = tgt_ram;
    end
    m.we = !b.mreq_n && !b.wr_n &&
           ((m.tgt inside {tgt_ram, tgt_vram, tgt_aram, tgt_hrg}) ||
            (m.tgt == tgt_chargen && r.char_latch[7]));
    return m;
  endfunction

  function automatic logic [7:0] ref_rdata(input cpu_bus_t b, input io_regs_t r,
                                           input logic [7:0] mem, input logic [7:0] key,
                                           input logic hb, input logic vb);
    if (!b.iorq_n || b.mreq_n) return 8'hFF;  // i/o space and idle bus float
    if (!page_hit(b, r)) return mem;
    case (b.addr[7:0])
      `VG_PORT_HRG0:    return {6'b11_1111, ~hb, ~vb};
      `VG_PORT_CTRL:    return key;
      `VG_PORT_COUNTER: return mem;  // chargen byte
      `VG_PORT_LATCH:   return {hb, vb, 5'b0_0000, r.key_ready};
      default:          return 8'h00;
    endcase
  endfunction

  function automatic video_cfg_t ref_video_cfg(input io_regs_t r);
    video_cfg_t v;
    v.mode80 = r.ctrl.mode80;
    v.counter = r.counter;
    v.hrg0 = r.hrg0;
    v.hrg1 = r.hrg1;
    return v;
  endfunction

  // register effects of one finished cycle
  task automatic apply_shadow(input cpu_bus_t b, input logic press);
    ctrl_reg_t old;
    logic wr;
    logic ctrl_wr;
    old = shadow.ctrl;
    wr = !b.mreq_n && b.iorq_n && !b.wr_n && page_hit(b, shadow);
    ctrl_wr = wr && b.addr[7:0] == `VG_PORT_CTRL;
    if (wr) begin
      case (b.addr[7:0])
        `VG_PORT_HRG0: shadow.hrg0 = b.wdata;
        `VG_PORT_HRG1: shadow.hrg1 = b.wdata;
        `VG_PORT_CTRL: shadow.ctrl = ctrl_reg_t'(b.wdata);
        `VG_PORT_COUNTER: begin
          if (!old.counter_lock && !old.chargen_sel) shadow.counter = b.wdata[4:0];
        end
        `VG_PORT_LATCH: begin
          if (old.chargen_sel) shadow.char_latch = b.wdata;
          else shadow.row_latch = b.wdata[3:0];
        end
        default: ;
      endcase
    end
    if (press) shadow.key_ready = 1'b1;  // set beats clear
    else if (ctrl_wr && !b.wdata[0]) shadow.key_ready = 1'b0;
    if (ctrl_wr && b.wdata[1]) nmi_cnt = 4'd0;
    else if (prev_m1 && !b.m1_n && !old.nmi_mask) nmi_cnt = nmi_cnt + 4'd1;
    prev_m1 = b.m1_n;
    shadow.nmi_n = !nmi_cnt[3];
  endtask

  // drive on the current rising edge and return on the next one
  task automatic run_cycle(input cpu_bus_t b, input logic press);
    bus       <= b;
    key_press <= press;
    mem_rdata <= 8'($urandom);
    key_code  <= 8'($urandom);
    hblank    <= 1'($urandom);
    vblank    <= 1'($urandom);
    @(posedge w_clk_cpu);
    apply_shadow(b, press);
  endtask

  task automatic page_write(input logic [7:0] port, input logic [7:0] d);
    run_cycle(mem_write({`VG_IO_PAGE, port}, d), 1'b0);
  endtask

  task automatic page_read(input logic [7:0] port);
    run_cycle(mem_read({`VG_IO_PAGE, port}), 1'b0);
  endtask

  task automatic report_failure();
    $display("Finished with errors");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_mem_req(input mem_req_t got, input mem_req_t exp);
    if (got !== exp) begin
      $display("Fail o_mem_req got %h expected %h (addr %h, bus %h)", got, exp,
               bus.addr, bus);
      report_failure();
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("Fail %s got %h expected %h (addr %h)", name, got, exp, bus.addr);
      report_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail %s got %h expected %h", name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_video_cfg(input video_cfg_t got, input video_cfg_t exp);
    if (got !== exp) begin
      $display("Fail o_video_cfg got %h expected %h", got, exp);
      report_failure();
    end
  endtask

  task automatic wait_nmi_level(input logic level, input int limit);
    int n;
    logic seen;
    n = 0;
    seen = 1'b0;
    while (!seen) begin
      run_cycle(idle_bus(), 1'b0);
      @(negedge w_clk_cpu);  // outputs settled mid cycle
      if (nmi_n === level) begin
        seen = 1'b1;
      end else if (n >= limit) begin
        $display("o_nmi_n did not go to %0d within %0d cycles", level, limit);
        report_failure();
      end
      n++;
      @(posedge w_clk_cpu);
    end
  endtask

  // compares every cycle in the middle of the clock low phase
  always @(negedge w_clk_cpu) begin
    if (check_en) begin
      check_mem_req(mem_req, ref_mem_req(bus, shadow));
      check_byte("o_cpu_rdata", cpu_rdata,
                 ref_rdata(bus, shadow, mem_rdata, key_code, hblank, vblank));
      check_bit("o_nmi_n", nmi_n, shadow.nmi_n);
      check_video_cfg(video_cfg, ref_video_cfg(shadow));
    end
  end

  initial begin
    int unsigned seed;
    seed = 32'hf5b5_5175;
    void'($urandom(seed));
    w_clk_cpu = 1'b0;
    w_cpu_reset = 1'b0;
    bus = idle_bus();
    mem_rdata = 8'h00;
    key_code = 8'h00;
    key_press = 1'b0;
    hblank = 1'b0;
    vblank = 1'b0;
    shadow = '0;
    shadow.nmi_n = 1'b1;
    nmi_cnt = 4'd0;
    prev_m1 = 1'b1;
    check_en = 1'b0;
    repeat (16) @(posedge w_clk_cpu);
    w_cpu_reset <= 1'b1;
    check_en = 1'b1;  // reset values checked from the first cycle on

    // memory map with rom in, then rom out
    repeat (300) run_cycle(random_cycle(), 1'b0);
    page_write(`VG_PORT_CTRL, 8'h81);
    repeat (300) run_cycle(random_cycle(), 1'b0);
    page_write(`VG_PORT_CTRL, 8'h01);

    // register writes and status reads
    page_write(`VG_PORT_HRG0, 8'($urandom) & 8'hFB);  // keep text routing
    page_write(`VG_PORT_HRG1, 8'($urandom));
    page_write(`VG_PORT_CTRL, 8'h21);
    repeat (20) begin
      page_read(`VG_PORT_HRG0);
      page_read(`VG_PORT_LATCH);
      page_read(`VG_PORT_HRG1);
      run_cycle(io_read(16'($urandom)), 1'b0);
      run_cycle(mem_read({`VG_IO_PAGE_ALT, 8'h00}), 1'b0);
    end

    // text window in all layouts, scroll load and lock
    for (int m = 0; m < 4; m++) begin
      page_write(`VG_PORT_LATCH, 8'($urandom));
      page_write(`VG_PORT_COUNTER, 8'($urandom));
      page_write(`VG_PORT_CTRL, {1'b0, m[1], m[0], 5'b0_0001});
      repeat (40) run_cycle(video_cycle(), 1'b0);
    end
    page_write(`VG_PORT_CTRL, 8'h11);
    page_write(`VG_PORT_COUNTER, {3'b000, ~shadow.counter});  // ignored while locked
    page_write(`VG_PORT_CTRL, 8'h01);
    page_write(`VG_PORT_COUNTER, {3'b000, ~shadow.counter});  // new value lands
    page_write(`VG_PORT_HRG0, 8'h04);
    for (int h = 0; h < 16; h++) begin
      page_write(`VG_PORT_HRG1, 8'(h) | (8'($urandom) & 8'hF0));  // full and tail banks
      repeat (10) run_cycle(video_cycle(), 1'b0);
    end
    page_write(`VG_PORT_HRG0, 8'h00);

    // character generator through FD
    page_write(`VG_PORT_LATCH, 8'($urandom));
    page_write(`VG_PORT_CTRL, 8'h09);
    page_write(`VG_PORT_LATCH, 8'($urandom) & 8'h7F);  // write protected
    page_read(`VG_PORT_COUNTER);
    page_write(`VG_PORT_COUNTER, 8'($urandom));
    page_write(`VG_PORT_LATCH, 8'($urandom) | 8'h80);
    page_read(`VG_PORT_COUNTER);
    page_write(`VG_PORT_COUNTER, 8'($urandom));
    run_cycle(mem_write({`VG_IO_PAGE_ALT, `VG_PORT_COUNTER}, 8'($urandom)), 1'b0);
    page_write(`VG_PORT_CTRL, 8'h01);

    // key flag set, read back, cleared
    run_cycle(idle_bus(), 1'b1);
    page_read(`VG_PORT_LATCH);
    page_read(`VG_PORT_CTRL);
    page_write(`VG_PORT_CTRL, 8'h00);
    page_read(`VG_PORT_LATCH);
    page_write(`VG_PORT_CTRL, 8'h01);

    // nmi after eight fetches, release, then masked
    page_write(`VG_PORT_CTRL, 8'h03);
    page_write(`VG_PORT_CTRL, 8'h01);
    repeat (8) begin
      run_cycle(opcode_fetch(16'($urandom) & 16'h3FFF), 1'b0);
      run_cycle(idle_bus(), 1'b0);
    end
    wait_nmi_level(1'b0, 4);
    page_write(`VG_PORT_CTRL, 8'h03);
    wait_nmi_level(1'b1, 4);
    repeat (10) begin
      run_cycle(opcode_fetch(16'($urandom) & 16'h3FFF), 1'b0);
      run_cycle(idle_bus(), 1'b0);
    end
    page_write(`VG_PORT_CTRL, 8'h01);
    run_cycle(idle_bus(), 1'b0);

    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire
